/* design/cc_defines.svh */
`ifndef CC_DEFINES_SVH
`define CC_DEFINES_SVH

// ==================================================
// rate defaults, in cycles between two requests
// ==================================================

// a larger value means a lower send rate
`define CC_RC_DEFAULT    64
`define CC_RT_DEFAULT    16
`define CC_R_MIN         16
`define CC_R_CAP         1024

// ==================================================
// decrease and recovery timing
// ==================================================

`define CC_DEC_GAP       200
`define CC_ALPHA_TIMEOUT 240
`define CC_TIME_THRESH   300
`define CC_BYTE_THRESH   8
`define CC_F             5
`define CC_ADD_STEP      8
`define CC_HYPER_STEP    16

// request queue sizing
`define CC_QDEPTH        8
`define CC_DATA_W        32

`endif

/* design/cc_pacer.sv */
`timescale 1ns/100ps

`include "cc_defines.svh"

module cc_pacer (
    input  logic                  aclk,
    input  logic                  aresetn,

    input  cc_pkg::rate_t         rate_cur,

    input  logic                  head_valid,
    input  logic [`CC_DATA_W-1:0] head_data,
    output logic                  head_ready,

    output logic                  m_valid,
    output logic [`CC_DATA_W-1:0] m_data,
    input  logic                  m_ready
);

    import cc_pkg::*;

    rate_t gap_cnt;
    logic  hold;
    logic  gate_open;

    // once offered, a request stays offered even if rate_cur grows meanwhile
    assign gate_open  = (gap_cnt > rate_cur) || hold;
    assign m_valid    = head_valid && gate_open;
    assign head_ready = m_ready && gate_open;
    assign m_data     = head_data;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            gap_cnt <= '0;
            hold    <= 1'b0;
        end else begin
            hold <= m_valid && !m_ready;
            if (m_valid && m_ready) begin
                gap_cnt <= '0;
            end else if (gap_cnt != '1) begin
                gap_cnt <= gap_cnt + 1'b1;
            end
        end
    end

endmodule

/* design/cc_pkg.sv */
package cc_pkg;

    // ==================================================
    // rate values and recovery phase
    // ==================================================

    localparam int rate_w = 16;

    typedef logic [rate_w-1:0] rate_t;

    // phase follows the time and packet stage counts
    typedef enum logic [1:0] {
        phase_fast_recovery,
        phase_additive,
        phase_hyper
    } cc_phase_t;

    // reduction factors with 7 fractional bits, index 0 doubles the gap
    localparam int sa_frac      = 7;
    localparam int sa_max_index = 28;

    localparam logic [8:0] sa_table [0:sa_max_index] = '{
        9'd256, 9'd241, 9'd228, 9'd218, 9'd209, 9'd201, 9'd194, 9'd188,
        9'd182, 9'd178, 9'd173, 9'd170, 9'd166, 9'd163, 9'd161, 9'd158,
        9'd156, 9'd154, 9'd152, 9'd150, 9'd148, 9'd147, 9'd146, 9'd144,
        9'd143, 9'd142, 9'd141, 9'd140, 9'd139
    };

endpackage

/* design/cc_queue.sv */
`timescale 1ns/100ps

`include "cc_defines.svh"

module cc_queue (
    input  logic                  aclk,
    input  logic                  aresetn,

    input  logic                  s_req_valid,
    output logic                  s_req_ready,
    input  logic [`CC_DATA_W-1:0] s_req_data,

    output logic                  m_req_valid,
    input  logic                  m_req_ready,
    output logic [`CC_DATA_W-1:0] m_req_data,

    input  logic                  ecn_write_rdy,
    input  logic                  ecn_mark,

    output cc_pkg::rate_t         rate_cur,
    output cc_pkg::rate_t         rate_tgt
);

    logic                  head_valid;
    logic                  head_ready;
    logic [`CC_DATA_W-1:0] head_data;
    logic                  dec_pulse;
    logic                  inc_event;
    logic [2:0]            tc_stage;
    logic [2:0]            bc_stage;

    // ==================================================
    // request path
    // ==================================================

    cc_req_fifo #(
        .DEPTH  (`CC_QDEPTH),
        .DATA_W (`CC_DATA_W)
    ) u_fifo (
        .aclk    (aclk),
        .aresetn (aresetn),
        .s_valid (s_req_valid),
        .s_ready (s_req_ready),
        .s_data  (s_req_data),
        .m_valid (head_valid),
        .m_ready (head_ready),
        .m_data  (head_data)
    );

    cc_pacer u_pacer (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .rate_cur   (rate_cur),
        .head_valid (head_valid),
        .head_data  (head_data),
        .head_ready (head_ready),
        .m_valid    (m_req_valid),
        .m_data     (m_req_data),
        .m_ready    (m_req_ready)
    );

    // ==================================================
    // rate control
    // ==================================================

    cc_recovery_counter u_rec (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .pkt_strobe (ecn_write_rdy),
        .dec_pulse  (dec_pulse),
        .inc_event  (inc_event),
        .tc_stage   (tc_stage),
        .bc_stage   (bc_stage)
    );

    cc_rate_ctrl u_ctrl (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .ecn_write_rdy (ecn_write_rdy),
        .ecn_mark      (ecn_mark),
        .inc_event     (inc_event),
        .tc_stage      (tc_stage),
        .bc_stage      (bc_stage),
        .dec_pulse     (dec_pulse),
        .rate_cur      (rate_cur),
        .rate_tgt      (rate_tgt)
    );

endmodule

/* design/cc_rate_ctrl.sv */
`timescale 1ns/100ps

`include "cc_defines.svh"

module cc_rate_ctrl (
    input  logic          aclk,
    input  logic          aresetn,

    input  logic          ecn_write_rdy,
    input  logic          ecn_mark,
    input  logic          inc_event,
    input  logic [2:0]    tc_stage,
    input  logic [2:0]    bc_stage,

    output logic          dec_pulse,
    output cc_pkg::rate_t rate_cur,
    output cc_pkg::rate_t rate_tgt
);

    import cc_pkg::*;

    localparam rate_t       RC_DEFAULT  = rate_t'(`CC_RC_DEFAULT);
    localparam rate_t       RT_DEFAULT  = rate_t'(`CC_RT_DEFAULT);
    localparam rate_t       R_MIN       = rate_t'(`CC_R_MIN);
    localparam rate_t       R_CAP       = rate_t'(`CC_R_CAP);
    localparam rate_t       ADD_STEP    = rate_t'(`CC_ADD_STEP);
    localparam rate_t       HYPER_STEP  = rate_t'(`CC_HYPER_STEP);
    localparam logic [23:0] DEC_GAP     = 24'(`CC_DEC_GAP);
    localparam logic [23:0] ALPHA_TOUT  = 24'(`CC_ALPHA_TIMEOUT);
    localparam logic [2:0]  STAGE_F     = 3'(`CC_F);

    logic [23:0] timer;
    logic [23:0] t_last_dec;
    logic [23:0] t_last_mark;
    logic        dec_seen;
    logic [4:0]  sa_idx;
    cc_phase_t   phase;
    rate_t       rc_q;
    rate_t       rt_q;
    logic        mark;
    logic        alpha_timeout;
    logic [24:0] rc_scaled;
    logic [16:0] rc_mid;
    rate_t       rc_calc;
    rate_t       rt_calc;
    rate_t       rc_next;
    rate_t       rt_next;

    assign mark = ecn_write_rdy && ecn_mark;

    // the first mark after reset always cuts, later ones need the gap
    assign dec_pulse = mark && (!dec_seen || (timer - t_last_dec > DEC_GAP));

    assign alpha_timeout = !mark && (timer - t_last_mark > ALPHA_TOUT);

    assign rate_cur = rc_q;
    assign rate_tgt = rt_q;

    always_comb begin
        if (tc_stage >= STAGE_F && bc_stage >= STAGE_F) begin
            phase = phase_hyper;
        end else if (tc_stage >= STAGE_F || bc_stage >= STAGE_F) begin
            phase = phase_additive;
        end else begin
            phase = phase_fast_recovery;
        end
    end

    // ==================================================
    // decrease and increase rules
    // ==================================================

    always_comb begin
        rc_scaled = rc_q * sa_table[sa_idx];
        rc_mid    = {1'b0, rc_q} + {1'b0, rt_q};
        rc_calc   = rc_q;
        rt_calc   = rt_q;

        if (dec_pulse) begin
            rt_calc = rc_q;
            if (rc_q <= R_CAP) begin
                rc_calc = rate_t'(rc_scaled >> sa_frac);
            end
        end else if (inc_event) begin
            // rc moves halfway toward the target on every event
            rc_calc = rc_mid[16:1];
            case (phase)
                phase_hyper: begin
                    rt_calc = (rt_q < R_MIN + HYPER_STEP) ? R_MIN : rt_q - HYPER_STEP;
                end
                phase_additive: begin
                    rt_calc = (rt_q < R_MIN + ADD_STEP) ? R_MIN : rt_q - ADD_STEP;
                end
                default: begin
                    rt_calc = rt_q;
                end
            endcase
        end

        rc_next = (rc_calc < R_MIN) ? R_MIN : rc_calc;
        rt_next = (rt_calc < R_MIN) ? R_MIN : rt_calc;
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            timer       <= '0;
            t_last_dec  <= '0;
            t_last_mark <= '0;
            dec_seen    <= 1'b0;
            sa_idx      <= '0;
            rc_q        <= RC_DEFAULT;
            rt_q        <= RT_DEFAULT;
        end else begin
            timer <= timer + 1'b1;
            rc_q  <= rc_next;
            rt_q  <= rt_next;

            if (dec_pulse) begin
                t_last_dec <= timer;
                dec_seen   <= 1'b1;
                if (sa_idx != '0) begin
                    sa_idx <= sa_idx - 1'b1;
                end
            end else if (alpha_timeout && sa_idx != 5'(sa_max_index)) begin
                sa_idx <= sa_idx + 1'b1;
            end

            // a long quiet spell restarts the timeout as if a mark was seen
            if (mark || alpha_timeout) begin
                t_last_mark <= timer;
            end
        end
    end

endmodule

/* design/cc_recovery_counter.sv */
`timescale 1ns/100ps

`include "cc_defines.svh"

module cc_recovery_counter (
    input  logic       aclk,
    input  logic       aresetn,

    input  logic       pkt_strobe,
    input  logic       dec_pulse,

    output logic       inc_event,
    output logic [2:0] tc_stage,
    output logic [2:0] bc_stage
);

    localparam logic [15:0] TIME_THRESH = 16'(`CC_TIME_THRESH);
    localparam logic [7:0]  BYTE_THRESH = 8'(`CC_BYTE_THRESH);
    localparam logic [2:0]  STAGE_MAX   = 3'(`CC_F);

    logic [15:0] time_cnt;
    logic [7:0]  pkt_cnt;

    // ==================================================
    // time and packet counters
    // ==================================================

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            time_cnt  <= '0;
            pkt_cnt   <= '0;
            tc_stage  <= '0;
            bc_stage  <= '0;
            inc_event <= 1'b0;
        end else if (dec_pulse) begin
            // a rate cut restarts the whole recovery sequence
            time_cnt  <= '0;
            pkt_cnt   <= '0;
            tc_stage  <= '0;
            bc_stage  <= '0;
            inc_event <= 1'b0;
        end else begin
            inc_event <= 1'b0;

            if (time_cnt > TIME_THRESH) begin
                time_cnt  <= '0;
                inc_event <= 1'b1;
                if (tc_stage < STAGE_MAX) begin
                    tc_stage <= tc_stage + 1'b1;
                end
            end else begin
                time_cnt <= time_cnt + 1'b1;
            end

            // the wrap cycle does not count a strobe
            if (pkt_cnt > BYTE_THRESH) begin
                pkt_cnt   <= '0;
                inc_event <= 1'b1;
                if (bc_stage < STAGE_MAX) begin
                    bc_stage <= bc_stage + 1'b1;
                end
            end else if (pkt_strobe) begin
                pkt_cnt <= pkt_cnt + 1'b1;
            end
        end
    end

endmodule

/* design/cc_req_fifo.sv */
`timescale 1ns/100ps

`include "cc_defines.svh"

module cc_req_fifo #(
    parameter int DEPTH  = `CC_QDEPTH,
    parameter int DATA_W = `CC_DATA_W
) (
    input  logic              aclk,
    input  logic              aresetn,

    input  logic              s_valid,
    output logic              s_ready,
    input  logic [DATA_W-1:0] s_data,

    output logic              m_valid,
    input  logic              m_ready,
    output logic [DATA_W-1:0] m_data
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [DATA_W-1:0] mem [0:DEPTH-1];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic [CNT_W-1:0]  count_next;
    logic              s_ready_q;
    logic              push;
    logic              pop;

    assign push    = s_valid && s_ready;
    assign pop     = m_valid && m_ready;
    assign s_ready = s_ready_q;
    assign m_valid = (count != '0);
    assign m_data  = mem[rd_ptr];

    always_comb begin
        count_next = count;
        if (push && !pop) begin
            count_next = count + 1'b1;
        end else if (pop && !push) begin
            count_next = count - 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            s_ready_q <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count     <= count_next;
            // ready is low in reset and rises on the first cycle after it
            s_ready_q <= (count_next != CNT_W'(DEPTH));
        end
    end

    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr] <= s_data;
        end
    end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# builds and runs the cc_queue testbench with Verilator from the project root
set -o pipefail
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f --top-module tb_cc_queue -o sim_cc_queue \
    && ./obj_dir/sim_cc_queue 2>&1 | tee sim.log \
    || { echo "build or simulation stopped with an error"; exit 1; }

grep -q "STATUS: FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "STATUS: PASS" sim.log || { echo "no status line in sim.log"; exit 1; }
echo "simulation passed"

/* test/cc_queue_sva.sv */
`timescale 1ns/100ps

`include "cc_defines.svh"

module cc_queue_sva (
    input  logic                  aclk,
    input  logic                  aresetn,
    input  logic                  s_req_ready,
    input  logic                  m_req_valid,
    input  logic                  m_req_ready,
    input  logic [`CC_DATA_W-1:0] m_req_data,
    input  cc_pkg::rate_t         rate_cur,
    input  cc_pkg::rate_t         rate_tgt
);

    // ==================================================
    // output handshake
    // ==================================================

    // a stalled request keeps its place and its payload
    hold_stable: assert property (@(posedge aclk) disable iff (!aresetn)
        m_req_valid && !m_req_ready |=> m_req_valid && $stable(m_req_data))
    else $error("request changed or dropped under back-pressure");

    quiet_reset: assert property (@(posedge aclk) !aresetn |=> !m_req_valid && !s_req_ready)
    else $error("handshake active right after reset");

    // ==================================================
    // rate floor
    // ==================================================

    cur_floor: assert property (@(posedge aclk) disable iff (!aresetn) rate_cur >= `CC_R_MIN)
    else $error("rate_cur below floor");

    tgt_floor: assert property (@(posedge aclk) disable iff (!aresetn) rate_tgt >= `CC_R_MIN)
    else $error("rate_tgt below floor");

endmodule

bind cc_queue cc_queue_sva u_sva (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .s_req_ready (s_req_ready),
    .m_req_valid (m_req_valid),
    .m_req_ready (m_req_ready),
    .m_req_data  (m_req_data),
    .rate_cur    (rate_cur),
    .rate_tgt    (rate_tgt)
);

/* test/cc_trace.txt */
// columns: request data, write strobe, ecn mark, ready stall cycles (all hex)
// a strobe value of 2 ends the trace
0000a001 1 0 0
0000a002 1 1 0
0000a003 0 0 3
0000a004 1 1 0
0000a005 1 0 0
0000a006 1 0 5
0000a007 1 0 0
0000a008 0 0 0
5a5a0009 1 0 a
5a5a000a 1 0 0
5a5a000b 1 0 0
5a5a000c 1 0 0
5a5a000d 1 1 4
5a5a000e 1 0 0
c3c3000f 1 1 0
c3c30010 1 0 10
c3c30011 1 0 0
00000000 2 0 0

/* test/tb_cc_queue.sv */
`timescale 1ns/100ps

`include "cc_defines.svh"

module tb_cc_queue;

    import cc_pkg::*;

    localparam int clk_period  = 40;
    localparam int wait_limit  = 4000;
    localparam int drain_limit = 20000;
    localparam int max_lines   = 64;

    logic                  aclk;
    logic                  aresetn;
    logic                  s_req_valid;
    logic                  s_req_ready;
    logic [`CC_DATA_W-1:0] s_req_data;
    logic                  m_req_valid;
    logic                  m_req_ready;
    logic [`CC_DATA_W-1:0] m_req_data;
    logic                  ecn_write_rdy;
    logic                  ecn_mark;
    rate_t                 rate_cur;
    rate_t                 rate_tgt;

    // four words per trace line: data, strobe, mark, stall
    logic [31:0]           trace_mem [0:4*max_lines-1];
    logic [`CC_DATA_W-1:0] expect_q [$];
    logic [`CC_DATA_W-1:0] held_data;
    int                    check_errors;
    int                    timeouts;
    int                    cyc;
    int                    stall_total;
    int                    stall_done;
    int                    rc_prev;
    int                    rt_prev;
    int                    last_dec_cyc;
    int                    last_out_cyc;
    int                    min_rc;
    bit                    have_prev;
    bit                    mark_prev;
    bit                    dec_done;
    bit                    have_out;
    bit                    stalled_prev;

    cc_queue u_cc_queue (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .s_req_valid   (s_req_valid),
        .s_req_ready   (s_req_ready),
        .s_req_data    (s_req_data),
        .m_req_valid   (m_req_valid),
        .m_req_ready   (m_req_ready),
        .m_req_data    (m_req_data),
        .ecn_write_rdy (ecn_write_rdy),
        .ecn_mark      (ecn_mark),
        .rate_cur      (rate_cur),
        .rate_tgt      (rate_tgt)
    );

    always #(clk_period / 2) aclk = ~aclk;

    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] want);
        $display("CHECK FAILED %s: got %h expected %h at cycle %0d", name, got, want, cyc);
        check_errors++;
    endtask

    // ==================================================
    // reference rules for the rate pair
    // ==================================================

    task automatic compare_rates();
        int rc_exp;
        int rt_lo8;
        int rt_lo16;
        int lo;
        int hi;
        if (rate_cur < `CC_R_MIN) report_value("rate_cur", rate_cur, `CC_R_MIN);
        if (rate_tgt < `CC_R_MIN) report_value("rate_tgt", rate_tgt, `CC_R_MIN);
        if (have_prev) begin
            if (mark_prev && (!dec_done || cyc - 1 - last_dec_cyc > `CC_DEC_GAP)) begin
                if (rate_tgt != rc_prev) report_value("rate_tgt", rate_tgt, rc_prev);
                lo = rc_prev;
                hi = rc_prev;
                if (rc_prev <= `CC_R_CAP && !dec_done) begin
                    lo = (rc_prev * 256) >> 7;
                    hi = lo;
                end else if (rc_prev <= `CC_R_CAP) begin
                    // the factor index has moved, so only the table range is known
                    lo = (rc_prev * 139) >> 7;
                    hi = (rc_prev * 256) >> 7;
                end
                if (rate_cur < lo || rate_cur > hi) report_value("rate_cur", rate_cur, hi);
                dec_done = 1'b1;
                last_dec_cyc = cyc - 1;
            end else if (mark_prev) begin
                if (rate_cur != rc_prev) report_value("rate_cur", rate_cur, rc_prev);
                if (rate_tgt != rt_prev) report_value("rate_tgt", rate_tgt, rt_prev);
            end else if (rate_cur != rc_prev || rate_tgt != rt_prev) begin
                rc_exp = (rc_prev + rt_prev) >> 1;
                rc_exp = (rc_exp < `CC_R_MIN) ? `CC_R_MIN : rc_exp;
                rt_lo8 = (rt_prev - `CC_ADD_STEP < `CC_R_MIN) ? `CC_R_MIN : rt_prev - `CC_ADD_STEP;
                rt_lo16 = (rt_prev - `CC_HYPER_STEP < `CC_R_MIN) ?
                          `CC_R_MIN : rt_prev - `CC_HYPER_STEP;
                if (rate_cur != rc_exp) report_value("rate_cur", rate_cur, rc_exp);
                if (rate_tgt != rt_prev && rate_tgt != rt_lo8 && rate_tgt != rt_lo16) begin
                    report_value("rate_tgt", rate_tgt, rt_prev);
                end
            end
        end
    endtask

    // ==================================================
    // output order, pacing and back-pressure
    // ==================================================

    task automatic track_output();
        logic [`CC_DATA_W-1:0] want;
        if (stalled_prev && m_req_valid !== 1'b1) report_value("m_req_valid", m_req_valid, 1);
        if (stalled_prev && m_req_data !== held_data) begin
            report_value("m_req_data", m_req_data, held_data);
        end
        if (rate_cur < min_rc) min_rc = rate_cur;
        if (m_req_valid && m_req_ready) begin
            if (expect_q.size() == 0) begin
                $display("output handshake without a matching input at cycle %0d", cyc);
                check_errors++;
            end else begin
                want = expect_q.pop_front();
                if (m_req_data !== want) report_value("m_req_data", m_req_data, want);
            end
            if (have_out && cyc - last_out_cyc <= min_rc) begin
                report_value("output gap", cyc - last_out_cyc, min_rc + 1);
            end
            have_out = 1'b1;
            last_out_cyc = cyc;
            min_rc = 32'h1_0000;
        end
        stalled_prev = m_req_valid && !m_req_ready;
        held_data = m_req_data;
    endtask

    always @(posedge aclk) begin
        if (aresetn) begin
            compare_rates();
            track_output();
            if (s_req_valid && s_req_ready) expect_q.push_back(s_req_data);
            rc_prev = rate_cur;
            rt_prev = rate_tgt;
            mark_prev = ecn_write_rdy && ecn_mark;
            have_prev = 1'b1;
            cyc++;
        end
    end

    // stall cycles booked by accepted trace lines hold ready low while a request is offered
    always @(negedge aclk) begin
        if (stall_done < stall_total && m_req_valid) begin
            m_req_ready = 1'b0;
            stall_done++;
        end else begin
            m_req_ready = 1'b1;
        end
    end

    task automatic drive_request(input int line, output bit ok);
        int waited;
        bit done;
        @(negedge aclk);
        s_req_valid   = 1'b1;
        s_req_data    = trace_mem[4*line];
        ecn_write_rdy = trace_mem[4*line+1][0];
        ecn_mark      = trace_mem[4*line+2][0];
        waited = 0;
        done = 1'b0;
        while (!done && waited < wait_limit) begin
            @(posedge aclk);
            done = s_req_valid && s_req_ready;
            if (done) stall_total += trace_mem[4*line+3];
            @(negedge aclk);
            ecn_write_rdy = 1'b0;
            ecn_mark      = 1'b0;
            waited++;
        end
        s_req_valid = 1'b0;
        ok = done;
        if (!done) begin
            $display("timeout: trace line %0d not accepted within %0d cycles", line, wait_limit);
            timeouts++;
        end
    endtask

    task automatic close_run();
        $display("errors: %0d check failures, %0d timeouts", check_errors, timeouts);
        if (check_errors == 0 && timeouts == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    endtask

    initial begin
        int line;
        int waited;
        bit ok;
        aclk          = 1'b0;
        aresetn       = 1'b0;
        s_req_valid   = 1'b0;
        s_req_data    = '0;
        m_req_ready   = 1'b1;
        ecn_write_rdy = 1'b0;
        ecn_mark      = 1'b0;
        check_errors  = 0;
        timeouts      = 0;
        cyc           = 0;
        stall_total   = 0;
        stall_done    = 0;
        min_rc        = 32'h1_0000;
        void'($urandom(32'h2f6e));
        $readmemh("test/cc_trace.txt", trace_mem);

        repeat (2) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;
        if (rate_cur !== `CC_RC_DEFAULT) report_value("rate_cur", rate_cur, `CC_RC_DEFAULT);
        if (rate_tgt !== `CC_RT_DEFAULT) report_value("rate_tgt", rate_tgt, `CC_RT_DEFAULT);
        if (m_req_valid !== 1'b0) report_value("m_req_valid", m_req_valid, 0);
        if (s_req_ready !== 1'b0) report_value("s_req_ready", s_req_ready, 0);

        line = 0;
        ok = 1'b1;
        while (ok && line < max_lines && trace_mem[4*line+1] !== 32'h2) begin
            drive_request(line, ok);
            repeat ($urandom % 3) @(negedge aclk);
            line++;
        end

        waited = 0;
        while (ok && expect_q.size() != 0 && waited < drain_limit) begin
            @(negedge aclk);
            waited++;
        end
        if (ok && expect_q.size() != 0) begin
            $display("timeout: %0d requests still queued after %0d cycles",
                     expect_q.size(), drain_limit);
            timeouts++;
        end
        close_run();
    end

endmodule

/* verilog.f */
+incdir+design
design/cc_pkg.sv
design/cc_req_fifo.sv
design/cc_recovery_counter.sv
design/cc_rate_ctrl.sv
design/cc_pacer.sv
design/cc_queue.sv
test/cc_queue_sva.sv
test/tb_cc_queue.sv
